//--- vlog.f
logic/lc3b_types.sv
logic/cache_types.sv
logic/cache_control.sv
logic/cache_tag_store.sv
logic/cache_data_store.sv
logic/cache_top.sv
tb/pmem_model.sv
tb/cache_checker.sv
tb/cache_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, then decide from the simulation log
verilator --binary --timing --timescale 1ns/1ns -f vlog.f --top-module cache_tb \
	-o cache_sim > build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }
./obj_dir/cache_sim > sim.log 2>&1
grep -qx "TB PASSED" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

//--- tb/cache_tb.sv
`timescale 1ns/1ns

// Cache testbench, table-driven accesses against a block memory model
module cache_tb;

	localparam int num_sets = 8;
	localparam int entries = 16;
	localparam int cycle_limit = entries * 40;	// Generous for three-cycle memory

	typedef struct packed {
		logic write;
		lc3b_types::lc3b_word address;
		lc3b_types::lc3b_word wdata;
		lc3b_types::lc3b_mem_wmask byte_enable;
		logic [1:0] transfers;	// Memory transfers the access should cause
	} access_row;

	// Set 0 blocks are 0x0000 A, 0x0080 B, 0x0100 C; set 1 holds 0x0190, 0x0210, 0x0310
	localparam access_row accesses [entries] = '{
		'{1'b0, 16'h0000, 16'h0000, 2'b00, 2'd1},	// A first read fills
		'{1'b0, 16'h0006, 16'h0000, 2'b00, 2'd0},	// Same block
		'{1'b1, 16'h0004, 16'hbeef, 2'b01, 2'd0},	// Low byte only
		'{1'b1, 16'h0008, 16'h1234, 2'b10, 2'd0},	// High byte only
		'{1'b0, 16'h0004, 16'h0000, 2'b00, 2'd0},
		'{1'b0, 16'h0008, 16'h0000, 2'b00, 2'd0},
		'{1'b1, 16'h0082, 16'hcafe, 2'b11, 2'd1},	// B allocated and dirty
		'{1'b0, 16'h0000, 16'h0000, 2'b00, 2'd0},	// A again, B least recent
		'{1'b0, 16'h0100, 16'h0000, 2'b00, 2'd2},	// C evicts dirty B
		'{1'b0, 16'h0082, 16'h0000, 2'b00, 2'd2},	// B from memory, evicts dirty A
		'{1'b0, 16'h0190, 16'h0000, 2'b00, 2'd1},
		'{1'b0, 16'h0210, 16'h0000, 2'b00, 2'd1},
		'{1'b0, 16'h0310, 16'h0000, 2'b00, 2'd1},	// Clean eviction, fill only
		'{1'b0, 16'h0008, 16'h0000, 2'b00, 2'd1},	// A back with merged bytes
		'{1'b1, 16'hfffe, 16'h7777, 2'b01, 2'd1},	// Last set, top word
		'{1'b0, 16'hfffe, 16'h0000, 2'b00, 2'd0}
	};

	logic clk;
	logic reset;
	logic mem_read;
	logic mem_write;
	logic mem_resp;
	lc3b_types::lc3b_word mem_address;
	lc3b_types::lc3b_word mem_wdata;
	lc3b_types::lc3b_word mem_rdata;
	lc3b_types::lc3b_word pmem_address;
	lc3b_types::lc3b_mem_wmask mem_byte_enable;
	logic pmem_read;
	logic pmem_write;
	logic pmem_resp;
	lc3b_types::lc3b_block pmem_rdata;
	lc3b_types::lc3b_block pmem_wdata;
	int checker_errors;
	int transfer_errors;
	int transfers;
	int cycles = 0;

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Run stopped after %0d cycles with the table unfinished", cycles);
			$display("Checker errors %0d, transfer count errors %0d, timeouts 1",
				checker_errors, transfer_errors);
			$display("TB FAILED");
			$finish;
		end
	end

	cache_top #(.num_sets(num_sets)) dut_i (
		.clk(clk), .reset(reset), .mem_read(mem_read), .mem_write(mem_write),
		.mem_address(mem_address), .mem_wdata(mem_wdata), .mem_byte_enable(mem_byte_enable),
		.mem_rdata(mem_rdata), .mem_resp(mem_resp), .pmem_read(pmem_read),
		.pmem_write(pmem_write), .pmem_address(pmem_address), .pmem_wdata(pmem_wdata),
		.pmem_rdata(pmem_rdata), .pmem_resp(pmem_resp)
	);

	pmem_model memory_i (
		.clk(clk), .reset(reset), .pmem_read(pmem_read), .pmem_write(pmem_write),
		.pmem_address(pmem_address), .pmem_wdata(pmem_wdata), .pmem_rdata(pmem_rdata),
		.pmem_resp(pmem_resp)
	);

	cache_checker #(.num_sets(num_sets)) checker_i (
		.clk(clk), .reset(reset), .mem_read(mem_read), .mem_write(mem_write),
		.mem_resp(mem_resp), .mem_address(mem_address), .mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata), .mem_byte_enable(mem_byte_enable), .pmem_read(pmem_read),
		.pmem_write(pmem_write), .pmem_resp(pmem_resp), .pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata), .errors(checker_errors)
	);

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_address = '0;
		mem_wdata = '0;
		mem_byte_enable = '0;
		transfer_errors = 0;
		repeat (10) @(posedge clk);
		#1 reset = 1'b0;
		repeat (3) @(posedge clk);	// Idle gap, nothing may move
		for (int i = 0; i < entries; i++) begin
			@(posedge clk);
			#1;
			mem_read = !accesses[i].write;
			mem_write = accesses[i].write;
			mem_address = accesses[i].address;
			mem_wdata = accesses[i].wdata;
			mem_byte_enable = accesses[i].byte_enable;
			transfers = 0;
			do begin	// Request held until the cache answers
				@(negedge clk);
				if (pmem_resp) begin
					transfers++;
				end
			end while (!mem_resp);
			if (transfers != int'(accesses[i].transfers)) begin
				$display("Mismatch at %0t: access %0d to %h made %0d memory transfers, expected %0d",
					$time, i, accesses[i].address, transfers, int'(accesses[i].transfers));
				transfer_errors++;
			end
		end
		@(posedge clk);
		#1;
		mem_read = 1'b0;
		mem_write = 1'b0;
		repeat (4) @(posedge clk);
		$display("Checker errors %0d, transfer count errors %0d, timeouts 0",
			checker_errors, transfer_errors);
		if (checker_errors == 0 && transfer_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule : cache_tb

//--- tb/cache_checker.sv
`timescale 1ns/1ns

// Shadow memory plus tag, dirty and LRU model checked against the cache ports
module cache_checker #(
	parameter int num_sets = 8
) (
	input  logic clk,
	input  logic reset,
	input  logic mem_read,
	input  logic mem_write,
	input  logic mem_resp,
	input  lc3b_types::lc3b_word mem_address,
	input  lc3b_types::lc3b_word mem_wdata,
	input  lc3b_types::lc3b_word mem_rdata,
	input  lc3b_types::lc3b_mem_wmask mem_byte_enable,
	input  logic pmem_read,
	input  logic pmem_write,
	input  logic pmem_resp,
	input  lc3b_types::lc3b_word pmem_address,
	input  lc3b_types::lc3b_block pmem_wdata,
	output int errors
);

	localparam int index_bits = $clog2(num_sets);

	lc3b_types::lc3b_word shadow [32768];	// What every word should hold
	cache_types::cache_tag tag_m [num_sets][2];
	logic [1:0] valid_m [num_sets];
	logic [1:0] dirty_m [num_sets];
	logic [num_sets-1:0] mru_m;	// Way used last in each set
	logic active;	// An access is in flight
	logic wb_due;
	logic fill_due;
	logic victim;
	logic way;
	logic [index_bits-1:0] set_index;
	cache_types::cache_tag req_tag;
	lc3b_types::lc3b_block expect_block;
	int seed;

	initial begin
		seed = 32'h7c85;	// Same sequence as the memory model
		for (int i = 0; i < 32768; i++) begin
			shadow[15'(i)] = 16'($random(seed));
		end
		errors = 0;
	end

	function automatic logic holds_block(input logic [index_bits-1:0] s, input logic w,
			input cache_types::cache_tag t);
		return valid_m[s][w] && (tag_m[s][w] == t);
	endfunction

	task automatic report_mismatch(input string msg);
		$display("Mismatch at %0t: %s", $time, msg);
		errors++;
	endtask

	// Sample mid-cycle while all ports are settled
	always @(negedge clk) begin
		set_index = mem_address[4 +: index_bits];
		req_tag = mem_address[15:4];
		if (reset) begin
			for (int s = 0; s < num_sets; s++) begin
				valid_m[s] = 2'b00;
				dirty_m[s] = 2'b00;
			end
			mru_m = '0;
			active = 1'b0;
			wb_due = 1'b0;
			fill_due = 1'b0;
		end else begin
			if (!active && (mem_read || mem_write)) begin	// New access
				active = 1'b1;
				victim = ~mru_m[set_index];	// Least recently used way
				fill_due = !holds_block(set_index, 1'b0, req_tag)
					&& !holds_block(set_index, 1'b1, req_tag);
				wb_due = fill_due && valid_m[set_index][victim] && dirty_m[set_index][victim];
			end
			if (!active && (mem_resp || pmem_read || pmem_write)) begin
				$display("Response or memory request at %0t with no access pending", $time);
				errors++;
			end
			if (pmem_resp && pmem_write) begin
				for (int k = 0; k < 8; k++) begin
					expect_block[k*16 +: 16] = shadow[{tag_m[set_index][victim], 3'(k)}];
				end
				if (!wb_due) begin
					$display("Write-back at %0t where the victim is clean or absent", $time);
					errors++;
				end else if (pmem_address !== {tag_m[set_index][victim], 4'h0}
						|| pmem_wdata !== expect_block) begin
					report_mismatch($sformatf("write-back of %h, expected block %h data %h",
						pmem_address, {tag_m[set_index][victim], 4'h0}, expect_block));
				end
				wb_due = 1'b0;
			end
			if (pmem_resp && pmem_read) begin
				if (!fill_due || wb_due) begin
					$display("Fill at %0t out of order or not needed", $time);
					errors++;
				end else if (pmem_address !== {req_tag, 4'h0}) begin
					report_mismatch($sformatf("fill from %h, expected %h", pmem_address,
						{req_tag, 4'h0}));
				end
				fill_due = 1'b0;
				valid_m[set_index][victim] = 1'b1;	// Block now in the victim way
				dirty_m[set_index][victim] = 1'b0;
				tag_m[set_index][victim] = req_tag;
			end
			if (mem_resp && active) begin
				way = holds_block(set_index, 1'b1, req_tag);
				if (fill_due || wb_due || !holds_block(set_index, way, req_tag)) begin
					$display("Response at %0t before the block was loaded", $time);
					errors++;
				end
				if (mem_read && mem_rdata !== shadow[mem_address[15:1]]) begin
					report_mismatch($sformatf("read of %h returned %h, expected %h",
						mem_address, mem_rdata, shadow[mem_address[15:1]]));
				end
				if (mem_write) begin
					if (mem_byte_enable[0]) begin
						shadow[mem_address[15:1]][7:0] = mem_wdata[7:0];
					end
					if (mem_byte_enable[1]) begin
						shadow[mem_address[15:1]][15:8] = mem_wdata[15:8];
					end
					dirty_m[set_index][way] = 1'b1;
				end
				mru_m[set_index] = way;
				active = 1'b0;
			end
		end
	end

endmodule : cache_checker

//--- tb/pmem_model.sv
`timescale 1ns/1ns

// Block memory behind the cache, answers each request three cycles after it appears
module pmem_model (
	input  logic clk,
	input  logic reset,
	input  logic pmem_read,
	input  logic pmem_write,
	input  lc3b_types::lc3b_word pmem_address,
	input  lc3b_types::lc3b_block pmem_wdata,
	output lc3b_types::lc3b_block pmem_rdata,
	output logic pmem_resp
);

	lc3b_types::lc3b_word mem [32768];	// Word addressed, whole 16-bit space
	int wait_count;	// Cycles the current request has waited
	int seed;

	initial begin
		seed = 32'h7c85;	// Same start as the shadow memory
		for (int i = 0; i < 32768; i++) begin
			mem[15'(i)] = 16'($random(seed));
		end
		pmem_resp = 1'b0;
		wait_count = 0;
	end

	// Block at the request address, word 0 in the low bits
	always_comb begin
		for (int k = 0; k < 8; k++) begin
			pmem_rdata[k*16 +: 16] = mem[{pmem_address[15:4], 3'(k)}];
		end
	end

	// Outputs move 1 ns after the edge
	always @(posedge clk) begin
		#1;
		if (reset || pmem_resp) begin	// One-cycle pulse, then ready again
			pmem_resp = 1'b0;
			wait_count = 0;
		end else if (pmem_read || pmem_write) begin
			if (wait_count == 2) begin
				pmem_resp = 1'b1;
				if (pmem_write) begin
					for (int k = 0; k < 8; k++) begin
						mem[{pmem_address[15:4], 3'(k)}] = pmem_wdata[k*16 +: 16];
					end
				end
			end else begin
				wait_count++;
			end
		end
	end

endmodule : pmem_model

//--- logic/cache_top.sv
`timescale 1ns/1ns

// Two-way write-back data cache
module cache_top #(
	parameter int num_sets = 8
) (
	input  logic clk,
	input  logic reset,

	// Processor side
	input  logic mem_read,
	input  logic mem_write,
	input  lc3b_types::lc3b_word mem_address,
	input  lc3b_types::lc3b_word mem_wdata,
	input  lc3b_types::lc3b_mem_wmask mem_byte_enable,
	output lc3b_types::lc3b_word mem_rdata,
	output logic mem_resp,

	// Memory side
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_types::lc3b_word pmem_address,
	output lc3b_types::lc3b_block pmem_wdata,
	input  lc3b_types::lc3b_block pmem_rdata,
	input  logic pmem_resp
);

	logic hit;
	logic dirty_victim;
	logic way_sel;	// Hit way or victim
	logic load_tags;
	logic load_block;
	logic write_hit;
	logic touch_lru;
	logic addr_sel;	// Victim address on write-back

	cache_control control_i (
		.clk(clk), .reset(reset),
		.mem_read(mem_read), .mem_write(mem_write), .mem_resp(mem_resp),
		.hit(hit), .dirty_victim(dirty_victim),
		.pmem_read(pmem_read), .pmem_write(pmem_write), .pmem_resp(pmem_resp),
		.load_tags(load_tags), .load_block(load_block), .write_hit(write_hit),
		.touch_lru(touch_lru), .addr_sel(addr_sel)
	);

	cache_tag_store #(.num_sets(num_sets)) tag_store_i (
		.clk(clk), .reset(reset), .mem_address(mem_address),
		.load_tags(load_tags), .write_hit(write_hit), .touch_lru(touch_lru),
		.addr_sel(addr_sel), .hit(hit), .dirty_victim(dirty_victim),
		.way_sel(way_sel), .pmem_address(pmem_address)
	);

	cache_data_store #(.num_sets(num_sets)) data_store_i (
		.clk(clk), .mem_address(mem_address), .mem_wdata(mem_wdata),
		.mem_byte_enable(mem_byte_enable), .pmem_rdata(pmem_rdata),
		.way_sel(way_sel), .load_block(load_block), .write_hit(write_hit),
		.mem_rdata(mem_rdata), .victim_block(pmem_wdata)
	);

endmodule : cache_top

//--- logic/cache_data_store.sv
`timescale 1ns/1ns

// Block storage for two ways, word read and byte-merged word write
module cache_data_store #(
	parameter int num_sets = 8
) (
	input  logic clk,

	input  lc3b_types::lc3b_word mem_address,
	input  lc3b_types::lc3b_word mem_wdata,
	input  lc3b_types::lc3b_mem_wmask mem_byte_enable,
	input  lc3b_types::lc3b_block pmem_rdata,	// Fill data

	input  logic way_sel,	// From the tag store
	input  logic load_block,
	input  logic write_hit,

	output lc3b_types::lc3b_word mem_rdata,
	output lc3b_types::lc3b_block victim_block	// Write-back data
);

	localparam int index_bits  = $clog2(num_sets);
	localparam int offset_bits = cache_types::block_offset_bits - cache_types::word_offset_lsb;
	localparam int word_bits   = $bits(lc3b_types::lc3b_word);
	localparam int byte_lanes  = $bits(lc3b_types::lc3b_mem_wmask);

	logic [index_bits-1:0] index;
	logic [offset_bits-1:0] offset;	// Word within the block

	lc3b_types::lc3b_block blocks [num_sets][2];
	lc3b_types::lc3b_block sel_block;	// Block in the chosen way
	lc3b_types::lc3b_word old_word;
	lc3b_types::lc3b_word merged_word;

	assign index  = mem_address[cache_types::block_offset_bits +: index_bits];
	assign offset = mem_address[cache_types::block_offset_bits-1:cache_types::word_offset_lsb];

	assign sel_block    = blocks[index][way_sel];
	assign old_word     = sel_block[offset*word_bits +: word_bits];
	assign mem_rdata    = old_word;
	assign victim_block = sel_block;	// LRU way while a miss is handled

	// Enabled bytes come from the store data
	always_comb begin
		for (int b = 0; b < byte_lanes; b++) begin
			merged_word[b*8 +: 8] = mem_byte_enable[b] ? mem_wdata[b*8 +: 8] : old_word[b*8 +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (load_block) begin
			blocks[index][way_sel] <= pmem_rdata;	// Whole block on fill
		end else if (write_hit) begin
			blocks[index][way_sel][offset*word_bits +: word_bits] <= merged_word;
		end
	end

endmodule : cache_data_store

//--- logic/cache_tag_store.sv
`timescale 1ns/1ns

// Valid, dirty, tag and LRU state for a two-way cache
module cache_tag_store #(
	parameter int num_sets = 8
) (
	input  logic clk,
	input  logic reset,

	input  lc3b_types::lc3b_word mem_address,	// Current request

	// Strobes from the controller
	input  logic load_tags,
	input  logic write_hit,
	input  logic touch_lru,
	input  logic addr_sel,

	output logic hit,
	output logic dirty_victim,
	output logic way_sel,	// Way the data store works on
	output lc3b_types::lc3b_word pmem_address
);

	localparam int index_bits = $clog2(num_sets);
	localparam int word_bits  = $bits(lc3b_types::lc3b_word);

	logic [index_bits-1:0] index;	// Set of the request
	cache_types::cache_tag req_tag;	// Tag of the request

	logic [1:0] valid [num_sets];	// One bit per way
	logic [1:0] dirty [num_sets];
	logic [num_sets-1:0] lru;	// Most recently used way of each set
	cache_types::cache_tag tags [num_sets][2];

	logic [1:0] way_hit;	// Per-way match
	logic victim;	// Way to replace on a miss

	lc3b_types::lc3b_word request_block_address;
	lc3b_types::lc3b_word victim_tag_address;

	// Address fields
	assign index   = mem_address[cache_types::block_offset_bits +: index_bits];
	assign req_tag = mem_address[word_bits-1:cache_types::block_offset_bits];

	// Compare both ways at once
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = valid[index][w] && (tags[index][w] == req_tag);
		end
	end

	assign hit    = |way_hit;
	assign victim = ~lru[index];	// The way not touched last

	// Only two ways, so way 1 matching settles it
	assign way_sel = hit ? way_hit[1] : victim;

	assign dirty_victim = dirty[index][victim];	// Dirty is only ever set on valid lines

	// Block-aligned addresses for memory
	assign request_block_address = {req_tag, {cache_types::block_offset_bits{1'b0}}};
	assign victim_tag_address    = {tags[index][victim], {cache_types::block_offset_bits{1'b0}}};

	assign pmem_address = addr_sel ? victim_tag_address : request_block_address;

	// Control bits
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int s = 0; s < num_sets; s++) begin
				valid[s] <= '0;
				dirty[s] <= '0;
			end
			lru <= '0;
		end else begin
			if (load_tags) begin
				valid[index][way_sel] <= 1'b1;	// Freshly filled
				dirty[index][way_sel] <= 1'b0;	// Matches memory
			end else if (write_hit) begin
				dirty[index][way_sel] <= 1'b1;	// Now differs from memory
			end

			if (touch_lru) begin
				lru[index] <= way_sel;
			end
		end
	end

	// Tag array
	always_ff @(posedge clk) begin
		if (load_tags) begin
			tags[index][way_sel] <= req_tag;
		end
	end

endmodule : cache_tag_store

//--- logic/cache_control.sv
`timescale 1ns/1ns

// Sequences hit, write-back and fill for one access at a time
module cache_control (
	input  logic clk,
	input  logic reset,

	// Processor request
	input  logic mem_read,
	input  logic mem_write,
	output logic mem_resp,

	// Status from the tag store
	input  logic hit,
	input  logic dirty_victim,

	// Memory handshake
	output logic pmem_read,
	output logic pmem_write,
	input  logic pmem_resp,

	// Strobes to the stores
	output logic load_tags,
	output logic load_block,
	output logic write_hit,
	output logic touch_lru,
	output logic addr_sel
);

	cache_types::cache_state state;	// Current state
	cache_types::cache_state next_state;
	logic request;	// Either kind of access is held

	assign request = mem_read | mem_write;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= cache_types::idle_check;
		end else begin
			state <= next_state;
		end
	end

	// Outputs and next state
	always_comb begin
		next_state = state;	// Hold by default
		mem_resp   = 1'b0;
		pmem_read  = 1'b0;
		pmem_write = 1'b0;
		load_tags  = 1'b0;
		load_block = 1'b0;
		write_hit  = 1'b0;
		touch_lru  = 1'b0;
		addr_sel   = 1'b0;	// Request block address to memory

		case (state)
			cache_types::idle_check: begin
				if (request && hit) begin
					mem_resp  = 1'b1;	// Same-cycle answer on hit
					touch_lru = 1'b1;	// Hit way becomes most recent
					write_hit = mem_write;	// Store merges into the hit way
				end else if (request) begin
					// Miss, so clear room first if the victim holds new data
					if (dirty_victim) begin
						next_state = cache_types::write_back;
					end else begin
						next_state = cache_types::fill;
					end
				end
			end

			cache_types::write_back: begin
				pmem_write = 1'b1;	// Held until memory answers
				addr_sel   = 1'b1;	// Victim's own address
				if (pmem_resp) begin
					next_state = cache_types::fill;
				end
			end

			cache_types::fill: begin
				pmem_read = 1'b1;	// Held until memory answers
				if (pmem_resp) begin
					load_tags  = 1'b1;	// Valid, tag, clean dirty
					load_block = 1'b1;	// Block lands in the victim way
					next_state = cache_types::idle_check;	// Retry hits now
				end
			end

			default: begin
				next_state = cache_types::idle_check;
			end
		endcase
	end

endmodule : cache_control

//--- logic/cache_types.sv
// Cache-internal types and address field positions
package cache_types;

	// Lowest address bit of the word offset (bit 0 picks a byte)
	parameter int word_offset_lsb = 1;

	// Low address bits spanned by one block (16 bytes)
	parameter int block_offset_bits = 4;

	// Tag is the whole block address above the offset
	// The index bits stay in the tag, so its width does not move with the set count
	typedef logic [$bits(lc3b_types::lc3b_word)-block_offset_bits-1:0] cache_tag;

	// Controller states
	typedef enum logic [1:0] {
		idle_check,	// Wait for a request, answer on hit
		write_back,	// Dirty victim goes out to memory
		fill		// Requested block comes in from memory
	} cache_state;

endpackage : cache_types

//--- logic/lc3b_types.sv
// Processor-side types shared by the cache and its testbench
package lc3b_types;

	// One 16-bit data or address word
	typedef logic [15:0] lc3b_word;

	// Byte enables for a word store
	// Bit 0 covers bits 7:0, bit 1 covers bits 15:8
	typedef logic [1:0] lc3b_mem_wmask;

	// A memory block holds eight words
	// Word 0 sits in bits 15:0, word 7 in bits 127:112
	typedef logic [127:0] lc3b_block;

endpackage : lc3b_types
